/* filelist.f */
+incdir+tests
design/decode_pkg.sv
design/regfile.sv
design/inst_decoder.sv
design/operand_forward.sv
design/branch_unit.sv
design/decode_stage.sv
tests/decode_stage_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  # Design, in compile order.
  - files:
      - design/decode_pkg.sv
      - design/regfile.sv
      - design/inst_decoder.sv
      - design/operand_forward.sv
      - design/branch_unit.sv
      - design/decode_stage.sv

  # Testbench top decode_stage_tb.
  - target: test
    include_dirs:
      - tests
    files:
      - tests/decode_stage_tb.sv

/* tests/decode_tests.svh */
localparam logic [31:0] BR_PC = 32'h1c00_0200;

function automatic logic [31:0] enc_3r(logic [3:0] f25, logic [1:0] f21, logic [4:0] f19,
                                       reg_addr_t rk, reg_addr_t rj, reg_addr_t rd);
    return {OPC_ALU_31_26, f25, f21, f19, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_ri12(logic [5:0] major, logic [3:0] f25, logic [11:0] i12,
                                         reg_addr_t rj, reg_addr_t rd);
    return {major, f25, i12, rj, rd};
endfunction

function automatic logic [31:0] enc_ri20(logic [5:0] major, logic [19:0] i20, reg_addr_t rd);
    return {major, 1'b0, i20, rd};
endfunction

function automatic logic [31:0] enc_ri16(logic [5:0] major, logic [15:0] i16,
                                         reg_addr_t rj, reg_addr_t rd);
    return {major, i16, rj, rd};
endfunction

function automatic logic [31:0] enc_i26(logic [5:0] major, logic [25:0] i26);
    return {major, i26[15:0], i26[25:16]}; // High offset bits sit in [9:0].
endfunction

function automatic fwd_t make_fwd(reg_addr_t dest, logic [31:0] result, logic is_load);
    return '{valid: 1'b1, gr_we: 1'b1, is_load: is_load, dest: dest, result: result};
endfunction

task automatic write_reg(reg_addr_t addr, logic [31:0] value);
    @(negedge clk);
    wb_fwd = make_fwd(addr, value, 1'b0);
    @(negedge clk);
    wb_fwd = '0;
endtask

// Offers one instruction to the stage and returns just after it is taken.
task automatic issue(logic [31:0] inst, logic [31:0] pc);
    int n;
    @(negedge clk);
    in_valid = 1'b1;
    in_bus   = '{pc: pc, inst: inst};
    n = 0;
    while (!allowin && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!allowin) begin
        timed_out("allowin");
    end
    @(negedge clk);
    in_valid = 1'b0;
    #1;
endtask

task automatic wait_out_valid();
    int n;
    n = 0;
    #1;
    while (!out_valid && n < TIMEOUT) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!out_valid) begin
        timed_out("out_valid");
    end
endtask

task automatic check_alu(string name, int alu_bit, logic [31:0] imm, logic src1_pc,
                         logic src2_imm, reg_addr_t dest);
    check_eq({name, " out_valid"}, 1, out_valid);
    check_eq({name, " alu_op"}, 32'd1 << alu_bit, out_bus.alu_op);
    if (src2_imm) begin
        check_eq({name, " imm"}, imm, out_bus.imm);
    end
    check_eq({name, " src1_is_pc"}, src1_pc, out_bus.src1_is_pc);
    check_eq({name, " src2_is_imm"}, src2_imm, out_bus.src2_is_imm);
    check_eq({name, " dest"}, dest, out_bus.dest);
    check_eq({name, " gr_we"}, 1, out_bus.gr_we);
endtask

task automatic test_alu_decode();
    start_test("alu_decode");
    check_eq("reset allowin", 1, allowin);
    check_eq("reset out_valid", 0, out_valid);
    check_eq("reset br.taken", 0, br.taken);
    check_eq("reset br.stall", 0, br.stall);
    write_reg(1, 32'h11);
    write_reg(2, 32'h22);
    issue(enc_3r(OPC_3R_25_22, OPC_3R_21_20, OPC_ADD_W_19_15, 2, 1, 5), 32'h1c00_0000);
    check_alu("add.w", ALU_ADD, 32'h0, 1'b0, 1'b0, 5);
    check_eq("add.w rj_value", 32'h11, out_bus.rj_value);
    check_eq("add.w rkd_value", 32'h22, out_bus.rkd_value);
    issue(enc_ri12(OPC_ALU_31_26, OPC_ADDI_W_25_22, 12'hff8, 1, 6), 32'h1c00_0004);
    check_alu("addi.w", ALU_ADD, 32'hffff_fff8, 1'b0, 1'b1, 6);
    check_eq("addi.w rj_value", 32'h11, out_bus.rj_value);
    issue(enc_ri12(OPC_ALU_31_26, OPC_ORI_25_22, 12'h8f0, 2, 7), 32'h1c00_0008);
    check_alu("ori", ALU_OR, 32'h0000_08f0, 1'b0, 1'b1, 7); // Zero extended.
    check_eq("ori rj_value", 32'h22, out_bus.rj_value);
    // Shift amount 3 lands in imm[4:0] below the slli.w function bits.
    issue(enc_3r(OPC_SHIFTI_25_22, OPC_SHIFTI_21_20, OPC_SLLI_W_19_15, 3, 1, 8), 32'h1c00_000c);
    check_alu("slli.w", ALU_SLL, 32'h0000_0023, 1'b0, 1'b1, 8);
    issue(enc_ri20(OPC_LU12I_W_31_26, 20'h12345, 9), 32'h1c00_0010);
    check_alu("lu12i.w", ALU_LUI, 32'h1234_5000, 1'b0, 1'b1, 9);
    issue(enc_ri20(OPC_PCADDU12I_31_26, 20'hfffff, 10), 32'h1c00_0100);
    check_alu("pcaddu12i", ALU_ADD, 32'hffff_f000, 1'b1, 1'b1, 10);
    check_eq("pcaddu12i pc", 32'h1c00_0100, out_bus.pc);
    end_test();
endtask

task automatic test_forward_priority();
    start_test("forward_priority");
    write_reg(4, 32'h44);
    @(negedge clk);
    exe_allowin = 1'b0; // Hold the instruction in decode.
    issue(enc_3r(OPC_3R_25_22, OPC_3R_21_20, OPC_ADD_W_19_15, 0, 4, 3), 32'h1c00_1000);
    check_eq("regfile value", 32'h44, out_bus.rj_value);
    @(negedge clk);
    exe_fwd = make_fwd(4, 32'haaaa_0001, 1'b0);
    mem_fwd = make_fwd(4, 32'hbbbb_0002, 1'b0);
    wb_fwd  = make_fwd(4, 32'hcccc_0003, 1'b0);
    #1;
    check_eq("execute first", 32'haaaa_0001, out_bus.rj_value);
    check_eq("r0 zero", 0, out_bus.rkd_value);
    @(negedge clk);
    exe_fwd = '0;
    #1;
    check_eq("memory next", 32'hbbbb_0002, out_bus.rj_value);
    @(negedge clk);
    mem_fwd = '0;
    #1;
    check_eq("writeback next", 32'hcccc_0003, out_bus.rj_value);
    @(negedge clk);
    wb_fwd = '0;
    #1;
    check_eq("written regfile", 32'hcccc_0003, out_bus.rj_value);
    @(negedge clk);
    exe_fwd = make_fwd(0, 32'hdead_beef, 1'b0);
    mem_fwd = make_fwd(0, 32'hdead_beef, 1'b0);
    #1;
    check_eq("r0 never forwarded", 0, out_bus.rkd_value);
    @(negedge clk);
    exe_fwd     = '0;
    mem_fwd     = '0;
    exe_allowin = 1'b1;
    end_test();
endtask

task automatic test_load_use();
    start_test("load_use");
    write_reg(6, 32'h66);
    @(negedge clk);
    exe_fwd = make_fwd(5, 32'h0, 1'b1);
    issue(enc_3r(OPC_3R_25_22, OPC_3R_21_20, OPC_ADD_W_19_15, 6, 5, 3), 32'h1c00_2000);
    check_eq("execute load out_valid", 0, out_valid);
    check_eq("execute load allowin", 0, allowin);
    check_eq("execute load br.stall", 1, br.stall);
    @(negedge clk);
    exe_fwd     = '0;
    mem_fwd     = make_fwd(5, 32'h5555_aaaa, 1'b1);
    mem_data_ok = 1'b0;
    #1;
    check_eq("memory load out_valid", 0, out_valid);
    check_eq("memory load br.stall", 1, br.stall);
    @(negedge clk);
    mem_data_ok = 1'b1;
    wait_out_valid();
    check_eq("load data rj_value", 32'h5555_aaaa, out_bus.rj_value);
    check_eq("load data rkd_value", 32'h66, out_bus.rkd_value);
    check_eq("released br.stall", 0, br.stall);
    @(negedge clk);
    mem_fwd = '0;
    end_test();
endtask

task automatic branch_case(string name, logic [31:0] inst, logic taken, logic [31:0] target);
    issue(inst, BR_PC);
    check_eq({name, " taken"}, taken, br.taken);
    if (taken) begin
        check_eq({name, " target"}, target, br.target);
    end
endtask

task automatic test_branches();
    start_test("branches");
    write_reg(11, 32'd5);
    write_reg(12, 32'hffff_fffb); // -5
    branch_case("beq", enc_ri16(OPC_BEQ_31_26, 16'h0004, 11, 11), 1'b1, BR_PC + 32'h10);
    branch_case("bne", enc_ri16(OPC_BNE_31_26, 16'h0004, 11, 11), 1'b0, 32'h0);
    branch_case("blt", enc_ri16(OPC_BLT_31_26, 16'hfffe, 12, 11), 1'b1, BR_PC - 32'd8);
    branch_case("bge", enc_ri16(OPC_BGE_31_26, 16'h0004, 12, 11), 1'b0, 32'h0);
    branch_case("bltu", enc_ri16(OPC_BLTU_31_26, 16'h0004, 12, 11), 1'b0, 32'h0);
    branch_case("bgeu", enc_ri16(OPC_BGEU_31_26, 16'h0100, 12, 11), 1'b1, BR_PC + 32'h400);
    branch_case("jirl", enc_ri16(OPC_JIRL_31_26, 16'h0010, 11, 1), 1'b1, 32'h45);
    branch_case("b", enc_i26(OPC_B_31_26, 26'h000_0100), 1'b1, BR_PC + 32'h400);
    branch_case("bl", enc_i26(OPC_BL_31_26, 26'h3ff_ffff), 1'b1, BR_PC - 32'd4);
    check_eq("bl dest", 1, out_bus.dest);
    check_eq("bl gr_we", 1, out_bus.gr_we);
    check_eq("bl link imm", 32'd4, out_bus.imm);
    end_test();
endtask

task automatic test_backpressure_flush();
    decode_bus_t held;
    int          i;
    start_test("backpressure_flush");
    @(negedge clk);
    exe_allowin = 1'b0;
    issue(enc_ri12(OPC_ALU_31_26, OPC_ADDI_W_25_22, 12'h041, 1, 13), 32'h1c00_3000);
    held = out_bus;
    for (i = 0; i < 3; i++) begin
        @(negedge clk);
        in_valid = 1'b1; // Fetch keeps offering the next one.
        in_bus   = '{pc: 32'h1c00_3004, inst: enc_ri20(OPC_LU12I_W_31_26, 20'h1, 14)};
        #1;
        check_eq("out_bus held", 1, out_bus === held);
        check_eq("allowin held low", 0, allowin);
    end
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    #1;
    check_eq("out_valid after flush", 0, out_valid);
    check_eq("allowin after flush", 1, allowin);
    @(negedge clk);
    in_valid = 1'b0;
    #1;
    check_eq("new inst out_valid", 1, out_valid);
    check_eq("new inst pc", 32'h1c00_3004, out_bus.pc);
    @(negedge clk);
    exe_allowin = 1'b1;
    end_test();
endtask

task automatic op_case(string name, logic [31:0] inst, md_op_t md, mem_op_t mem, logic we);
    issue(inst, 32'h1c00_4000);
    check_eq({name, " md_op"}, md, out_bus.md_op);
    check_eq({name, " mem_op"}, mem, out_bus.mem_op);
    check_eq({name, " gr_we"}, we, out_bus.gr_we);
endtask

task automatic test_muldiv_mem();
    start_test("muldiv_mem");
    op_case("mulh.wu", enc_3r(OPC_3R_25_22, OPC_3R_21_20, OPC_MULH_WU_19_15, 2, 1, 15),
            md_op_t'{mulh: 1'b1, unsigned_md: 1'b1, mul_op: MUL_OP_HU, default: '0}, '0, 1'b1);
    op_case("div.w", enc_3r(OPC_3R_25_22, OPC_DIVMOD_21_20, OPC_DIV_W_19_15, 2, 1, 16),
            md_op_t'{div: 1'b1, default: '0}, '0, 1'b1);
    op_case("mod.wu", enc_3r(OPC_3R_25_22, OPC_DIVMOD_21_20, OPC_MOD_WU_19_15, 2, 1, 16),
            md_op_t'{mod: 1'b1, unsigned_md: 1'b1, default: '0}, '0, 1'b1);
    op_case("ld.bu", enc_ri12(OPC_MEM_31_26, OPC_LD_BU_25_22, 12'h004, 1, 17), '0,
            mem_op_t'{load: 1'b1, byte_op: 1'b1, unsigned_ld: 1'b1, default: '0}, 1'b1);
    op_case("ld.h", enc_ri12(OPC_MEM_31_26, OPC_LD_H_25_22, 12'h006, 1, 18), '0,
            mem_op_t'{load: 1'b1, half_op: 1'b1, default: '0}, 1'b1);
    op_case("st.b", enc_ri12(OPC_MEM_31_26, OPC_ST_B_25_22, 12'h008, 1, 2), '0,
            mem_op_t'{store: 1'b1, byte_op: 1'b1, default: '0}, 1'b0);
    end_test();
endtask

/* tests/decode_stage_tb.sv */
`timescale 1ns/1ns

module decode_stage_tb import decode_pkg::*; ();

    localparam int TIMEOUT = 50; // Cycles per wait loop.

    logic        clk;
    logic        reset;
    logic        in_valid;
    fetch_bus_t  in_bus;
    logic        allowin;
    logic        exe_allowin;
    logic        out_valid;
    decode_bus_t out_bus;
    branch_t     br;
    fwd_t        exe_fwd;
    fwd_t        mem_fwd;
    fwd_t        wb_fwd;
    logic        mem_data_ok;
    logic        flush;

    int    errors;
    int    errors_at_start;
    int    tests;
    string test_name;

    decode_stage decode_stage_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .allowin     (allowin),
        .exe_allowin (exe_allowin),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .br          (br),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .mem_data_ok (mem_data_ok),
        .flush       (flush)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic timed_out(string what);
        $display("%s: %s did not come within %0d cycles", test_name, what, TIMEOUT);
        errors++;
    endtask

    task automatic start_test(string name);
        test_name       = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%-20s done, %0d errors", test_name, errors - errors_at_start);
    endtask

    `include "decode_tests.svh"

    initial begin
        errors      = 0;
        tests       = 0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_bus      = '0;
        exe_allowin = 1'b1;
        exe_fwd     = '0;
        mem_fwd     = '0;
        wb_fwd      = '0;
        mem_data_ok = 1'b1;
        flush       = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;

        test_alu_decode();
        test_forward_priority();
        test_load_use();
        test_branches();
        test_backpressure_flush();
        test_muldiv_mem();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  fetch_bus_t  in_bus,
    output logic        allowin,
    input  logic        exe_allowin,
    output logic        out_valid,
    output decode_bus_t out_bus,
    output branch_t     br,
    input  fwd_t        exe_fwd,
    input  fwd_t        mem_fwd,
    input  fwd_t        wb_fwd,
    input  logic        mem_data_ok,
    input  logic        flush
);

    logic            valid;
    logic            ready;
    fetch_bus_t      id_bus;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;
    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;
    logic            rj_hazard;
    logic            rkd_hazard;
    branch_kind_t    kind;
    logic [XLEN-1:0] offs;
    logic            taken;
    logic [XLEN-1:0] target;

    assign ready     = !(rj_hazard || rkd_hazard) || flush;
    assign allowin   = !valid || (ready && exe_allowin);
    assign out_valid = valid && ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (allowin && in_valid) begin
            id_bus <= in_bus; // Held while stalled.
        end
    end

    inst_decoder decoder_i (
        .inst      (id_bus.inst),
        .pc        (id_bus.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .rs1       (rs1),
        .rs2       (rs2),
        .ctrl      (out_bus),
        .kind      (kind),
        .offs      (offs)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_fwd.valid && wb_fwd.gr_we),
        .waddr  (wb_fwd.dest),
        .wdata  (wb_fwd.result)
    );

    operand_forward rj_fwd_i (
        .addr        (rs1),
        .rf_data     (rf_rdata1),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .mem_data_ok (mem_data_ok),
        .value       (rj_value),
        .hazard      (rj_hazard)
    );

    operand_forward rkd_fwd_i (
        .addr        (rs2),
        .rf_data     (rf_rdata2),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .mem_data_ok (mem_data_ok),
        .value       (rkd_value),
        .hazard      (rkd_hazard)
    );

    branch_unit branch_i (
        .kind      (kind),
        .pc        (id_bus.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .offs      (offs),
        .taken     (taken),
        .target    (target)
    );

    assign br = '{stall: valid && !ready, taken: valid && taken, target: target};

    // A flushed slot must not reach execute.
    no_valid_after_flush: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out_valid);

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit import decode_pkg::*; (
    input  branch_kind_t    kind,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    input  logic [XLEN-1:0] offs,
    output logic            taken,
    output logic [XLEN-1:0] target
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    always_comb begin
        case (kind)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = !lt;
            BR_BLTU: taken = ltu;
            BR_BGEU: taken = !ltu;
            BR_JIRL,
            BR_B,
            BR_BL:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative.
    assign target = ((kind == BR_JIRL) ? rj_value : pc) + offs;

endmodule

/* design/operand_forward.sv */
`timescale 1ns/1ns

module operand_forward import decode_pkg::*; (
    input  reg_addr_t       addr,
    input  logic [XLEN-1:0] rf_data,
    input  fwd_t            exe_fwd,
    input  fwd_t            mem_fwd,
    input  fwd_t            wb_fwd,
    input  logic            mem_data_ok,
    output logic [XLEN-1:0] value,
    output logic            hazard
);

    logic exe_sel;
    logic mem_sel;
    logic wb_sel;

    function automatic logic hit(fwd_t f, reg_addr_t a);
        return a != '0 && f.valid && f.gr_we && f.dest == a;
    endfunction

    // Youngest producer wins.
    assign exe_sel = hit(exe_fwd, addr);
    assign mem_sel = hit(mem_fwd, addr) && !exe_sel;
    assign wb_sel  = hit(wb_fwd, addr) && !exe_sel && !mem_sel;

    always_comb begin
        if (exe_sel) begin
            value = exe_fwd.result;
        end else if (mem_sel) begin
            value = mem_fwd.result;
        end else if (wb_sel) begin
            value = wb_fwd.result;
        end else begin
            value = rf_data;
        end
    end

    // Load data not yet available.
    assign hazard = (exe_sel && exe_fwd.is_load) || (mem_sel && mem_fwd.is_load && !mem_data_ok);

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder import decode_pkg::*; (
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    output reg_addr_t       rs1,
    output reg_addr_t       rs2,
    output decode_bus_t     ctrl,
    output branch_kind_t    kind,
    output logic [XLEN-1:0] offs
);

    logic [5:0]      op_31_26;
    logic [3:0]      op_25_22;
    logic [1:0]      op_21_20;
    logic [4:0]      op_19_15;
    reg_addr_t       rd;
    reg_addr_t       rj;
    reg_addr_t       rk;
    logic [11:0]     i12;
    logic [19:0]     i20;
    logic [15:0]     i16;
    logic [25:0]     i26;
    alu_op_t         alu_op;
    md_op_t          md;
    mem_op_t         mem;
    logic            need_si20;
    logic            need_ui12;
    logic            src2_is_4;
    logic            src2_is_imm;
    logic            rd_is_src;
    logic            gr_we;
    logic [XLEN-1:0] imm;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};

    always_comb begin
        alu_op    = '0;
        md        = '0;
        mem       = '0;
        kind      = BR_NONE;
        need_si20 = 1'b0;
        case (op_31_26)
            OPC_ALU_31_26: begin
                if (op_25_22 == OPC_3R_25_22 && op_21_20 == OPC_3R_21_20) begin
                    case (op_19_15)
                        OPC_ADD_W_19_15:   alu_op[ALU_ADD] = 1'b1;
                        OPC_SUB_W_19_15:   alu_op[ALU_SUB] = 1'b1;
                        OPC_SLT_19_15:     alu_op[ALU_SLT] = 1'b1;
                        OPC_SLTU_19_15:    alu_op[ALU_SLTU] = 1'b1;
                        OPC_NOR_19_15:     alu_op[ALU_NOR] = 1'b1;
                        OPC_AND_19_15:     alu_op[ALU_AND] = 1'b1;
                        OPC_OR_19_15:      alu_op[ALU_OR] = 1'b1;
                        OPC_XOR_19_15:     alu_op[ALU_XOR] = 1'b1;
                        OPC_SLL_W_19_15:   alu_op[ALU_SLL] = 1'b1;
                        OPC_SRL_W_19_15:   alu_op[ALU_SRL] = 1'b1;
                        OPC_SRA_W_19_15:   alu_op[ALU_SRA] = 1'b1;
                        OPC_MUL_W_19_15:   md = '{mul: 1'b1, mul_op: MUL_OP_W, default: '0};
                        OPC_MULH_W_19_15:  md = '{mulh: 1'b1, mul_op: MUL_OP_H, default: '0};
                        OPC_MULH_WU_19_15: md = '{mulh: 1'b1, unsigned_md: 1'b1,
                                                  mul_op: MUL_OP_HU, default: '0};
                        default: ;
                    endcase
                end else if (op_25_22 == OPC_3R_25_22 && op_21_20 == OPC_DIVMOD_21_20) begin
                    case (op_19_15)
                        OPC_DIV_W_19_15:  md = '{div: 1'b1, default: '0};
                        OPC_MOD_W_19_15:  md = '{mod: 1'b1, default: '0};
                        OPC_DIV_WU_19_15: md = '{div: 1'b1, unsigned_md: 1'b1, default: '0};
                        OPC_MOD_WU_19_15: md = '{mod: 1'b1, unsigned_md: 1'b1, default: '0};
                        default: ;
                    endcase
                end else if (op_25_22 == OPC_SHIFTI_25_22 && op_21_20 == OPC_SHIFTI_21_20) begin
                    case (op_19_15)
                        OPC_SLLI_W_19_15: alu_op[ALU_SLL] = 1'b1;
                        OPC_SRLI_W_19_15: alu_op[ALU_SRL] = 1'b1;
                        OPC_SRAI_W_19_15: alu_op[ALU_SRA] = 1'b1;
                        default: ;
                    endcase
                end else begin
                    case (op_25_22)
                        OPC_SLTI_25_22:   alu_op[ALU_SLT] = 1'b1;
                        OPC_SLTUI_25_22:  alu_op[ALU_SLTU] = 1'b1;
                        OPC_ADDI_W_25_22: alu_op[ALU_ADD] = 1'b1;
                        OPC_ANDI_25_22:   alu_op[ALU_AND] = 1'b1;
                        OPC_ORI_25_22:    alu_op[ALU_OR] = 1'b1;
                        OPC_XORI_25_22:   alu_op[ALU_XOR] = 1'b1;
                        default: ;
                    endcase
                end
            end
            OPC_LU12I_W_31_26: begin
                alu_op[ALU_LUI] = !inst[25];
                need_si20       = !inst[25];
            end
            OPC_PCADDU12I_31_26: begin
                alu_op[ALU_ADD] = !inst[25];
                need_si20       = !inst[25];
            end
            OPC_MEM_31_26: begin
                case (op_25_22)
                    OPC_LD_B_25_22:  mem = '{load: 1'b1, byte_op: 1'b1, default: '0};
                    OPC_LD_H_25_22:  mem = '{load: 1'b1, half_op: 1'b1, default: '0};
                    OPC_LD_W_25_22:  mem = '{load: 1'b1, default: '0};
                    OPC_LD_BU_25_22: mem = '{load: 1'b1, byte_op: 1'b1, unsigned_ld: 1'b1,
                                             default: '0};
                    OPC_LD_HU_25_22: mem = '{load: 1'b1, half_op: 1'b1, unsigned_ld: 1'b1,
                                             default: '0};
                    OPC_ST_B_25_22:  mem = '{store: 1'b1, byte_op: 1'b1, default: '0};
                    OPC_ST_H_25_22:  mem = '{store: 1'b1, half_op: 1'b1, default: '0};
                    OPC_ST_W_25_22:  mem = '{store: 1'b1, default: '0};
                    default: ;
                endcase
                alu_op[ALU_ADD] = mem.load | mem.store; // Address add.
            end
            OPC_JIRL_31_26: kind = BR_JIRL;
            OPC_B_31_26:    kind = BR_B;
            OPC_BL_31_26:   kind = BR_BL;
            OPC_BEQ_31_26:  kind = BR_BEQ;
            OPC_BNE_31_26:  kind = BR_BNE;
            OPC_BLT_31_26:  kind = BR_BLT;
            OPC_BGE_31_26:  kind = BR_BGE;
            OPC_BLTU_31_26: kind = BR_BLTU;
            OPC_BGEU_31_26: kind = BR_BGEU;
            default: ;
        endcase
        if (kind == BR_JIRL || kind == BR_BL) begin
            alu_op[ALU_ADD] = 1'b1; // Link value pc + 4.
        end
    end

    assign src2_is_4   = kind == BR_JIRL || kind == BR_BL;
    assign src2_is_imm = !(op_31_26 == OPC_ALU_31_26 && op_25_22 == OPC_3R_25_22);
    assign need_ui12   = src2_is_imm && (alu_op[ALU_AND] || alu_op[ALU_OR] || alu_op[ALU_XOR]);
    assign rd_is_src   = mem.store || kind inside {[BR_BEQ:BR_BGEU]};
    // Undefined encodings end up with no operation and no write.
    assign gr_we = (|alu_op && !mem.store) || md.mul || md.mulh || md.div || md.mod;

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {i20, 12'b0} :
                 need_ui12 ? {20'b0, i12} :
                             {{20{i12[11]}}, i12};

    assign offs = (kind == BR_B || kind == BR_BL) ? {{4{i26[25]}}, i26, 2'b0} :
                                                    {{14{i16[15]}}, i16, 2'b0};

    assign rs1 = rj;
    assign rs2 = rd_is_src ? rd : rk;

    assign ctrl = '{
        pc:          pc,
        rj_value:    rj_value,
        rkd_value:   rkd_value,
        imm:         imm,
        alu_op:      alu_op,
        md_op:       md,
        mem_op:      mem,
        src1_is_pc:  src2_is_4 || (op_31_26 == OPC_PCADDU12I_31_26),
        src2_is_imm: src2_is_imm,
        gr_we:       gr_we,
        dest:        (kind == BR_BL) ? reg_addr_t'(1) : rd
    };

endmodule

/* design/regfile.sv */
`timescale 1ns/1ns

module regfile import decode_pkg::*; (
    input  logic            clk,
    input  reg_addr_t       raddr1,
    input  reg_addr_t       raddr2,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2,
    input  logic            we,
    input  reg_addr_t       waddr,
    input  logic [XLEN-1:0] wdata
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is never stored.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/decode_pkg.sv */
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [11:0]           alu_op_t;

    // Bit positions in the one-hot alu_op_t.
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [2:0] MUL_OP_W  = 3'b001; // Low word.
    localparam logic [2:0] MUL_OP_H  = 3'b010;
    localparam logic [2:0] MUL_OP_HU = 3'b100;

    typedef struct packed {
        logic       mul;
        logic       mulh;
        logic       div;
        logic       mod;
        logic       unsigned_md;
        logic [2:0] mul_op;
    } md_op_t;

    typedef struct packed {
        logic load;
        logic store;
        logic byte_op;
        logic half_op;
        logic unsigned_ld;
    } mem_op_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JIRL,
        BR_B,
        BR_BL
    } branch_kind_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_bus_t;

    // Result view of a later stage.
    typedef struct packed {
        logic            valid;
        logic            gr_we;
        logic            is_load;
        reg_addr_t       dest;
        logic [XLEN-1:0] result;
    } fwd_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rj_value;
        logic [XLEN-1:0] rkd_value;
        logic [XLEN-1:0] imm;
        alu_op_t         alu_op;
        md_op_t          md_op;
        mem_op_t         mem_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic            gr_we;
        reg_addr_t       dest;
    } decode_bus_t;

    typedef struct packed {
        logic            stall;
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_t;

    // Major opcode, inst[31:26].
    localparam logic [5:0] OPC_ALU_31_26       = 6'h00;
    localparam logic [5:0] OPC_LU12I_W_31_26   = 6'h05;
    localparam logic [5:0] OPC_PCADDU12I_31_26 = 6'h07;
    localparam logic [5:0] OPC_MEM_31_26       = 6'h0a;
    localparam logic [5:0] OPC_JIRL_31_26      = 6'h13;
    localparam logic [5:0] OPC_B_31_26         = 6'h14;
    localparam logic [5:0] OPC_BL_31_26        = 6'h15;
    localparam logic [5:0] OPC_BEQ_31_26       = 6'h16;
    localparam logic [5:0] OPC_BNE_31_26       = 6'h17;
    localparam logic [5:0] OPC_BLT_31_26       = 6'h18;
    localparam logic [5:0] OPC_BGE_31_26       = 6'h19;
    localparam logic [5:0] OPC_BLTU_31_26      = 6'h1a;
    localparam logic [5:0] OPC_BGEU_31_26      = 6'h1b;

    // inst[25:22].
    localparam logic [3:0] OPC_3R_25_22     = 4'h0;
    localparam logic [3:0] OPC_SHIFTI_25_22 = 4'h1;
    localparam logic [3:0] OPC_SLTI_25_22   = 4'h8;
    localparam logic [3:0] OPC_SLTUI_25_22  = 4'h9;
    localparam logic [3:0] OPC_ADDI_W_25_22 = 4'ha;
    localparam logic [3:0] OPC_ANDI_25_22   = 4'hd;
    localparam logic [3:0] OPC_ORI_25_22    = 4'he;
    localparam logic [3:0] OPC_XORI_25_22   = 4'hf;
    localparam logic [3:0] OPC_LD_B_25_22   = 4'h0; // Under OPC_MEM_31_26.
    localparam logic [3:0] OPC_LD_H_25_22   = 4'h1;
    localparam logic [3:0] OPC_LD_W_25_22   = 4'h2;
    localparam logic [3:0] OPC_ST_B_25_22   = 4'h4;
    localparam logic [3:0] OPC_ST_H_25_22   = 4'h5;
    localparam logic [3:0] OPC_ST_W_25_22   = 4'h6;
    localparam logic [3:0] OPC_LD_BU_25_22  = 4'h8;
    localparam logic [3:0] OPC_LD_HU_25_22  = 4'h9;

    // inst[21:20].
    localparam logic [1:0] OPC_SHIFTI_21_20 = 2'h0;
    localparam logic [1:0] OPC_3R_21_20     = 2'h1;
    localparam logic [1:0] OPC_DIVMOD_21_20 = 2'h2;

    // inst[19:15].
    localparam logic [4:0] OPC_ADD_W_19_15   = 5'h00;
    localparam logic [4:0] OPC_SUB_W_19_15   = 5'h02;
    localparam logic [4:0] OPC_SLT_19_15     = 5'h04;
    localparam logic [4:0] OPC_SLTU_19_15    = 5'h05;
    localparam logic [4:0] OPC_NOR_19_15     = 5'h08;
    localparam logic [4:0] OPC_AND_19_15     = 5'h09;
    localparam logic [4:0] OPC_OR_19_15      = 5'h0a;
    localparam logic [4:0] OPC_XOR_19_15     = 5'h0b;
    localparam logic [4:0] OPC_SLL_W_19_15   = 5'h0e;
    localparam logic [4:0] OPC_SRL_W_19_15   = 5'h0f;
    localparam logic [4:0] OPC_SRA_W_19_15   = 5'h10;
    localparam logic [4:0] OPC_MUL_W_19_15   = 5'h18;
    localparam logic [4:0] OPC_MULH_W_19_15  = 5'h19;
    localparam logic [4:0] OPC_MULH_WU_19_15 = 5'h1a;
    localparam logic [4:0] OPC_DIV_W_19_15   = 5'h00;
    localparam logic [4:0] OPC_MOD_W_19_15   = 5'h01;
    localparam logic [4:0] OPC_DIV_WU_19_15  = 5'h02;
    localparam logic [4:0] OPC_MOD_WU_19_15  = 5'h03;
    localparam logic [4:0] OPC_SLLI_W_19_15  = 5'h01;
    localparam logic [4:0] OPC_SRLI_W_19_15  = 5'h09;
    localparam logic [4:0] OPC_SRAI_W_19_15  = 5'h11;

endpackage
